// ==== build.f ====
hw/nic_rx_pkg.sv
hw/host_reg_decoder.sv
hw/rx_dma_writer.sv
hw/irq_ctrl.sv
hw/link_arbiter.sv
hw/pcie_endpoint_driver.sv
verif/tb_pcie_endpoint_driver.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the receive-path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_pcie_endpoint_driver
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "No result line in $LOG"
    exit 1
fi
exit 0

// ==== verif/tb_pcie_endpoint_driver.sv ====
// Testbench for the PCIe endpoint driver receive path
// Applies host register writes and buffer commits from a table, models the
// receive buffer and the interrupt core, and checks every TLP on the TRN link
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_endpoint_driver;

    localparam int          NUM_ROWS    = 10;
    localparam int          IRQ_WINDOW  = 20;          // Quiet cycles closing each test
    localparam int          P_NONE      = 0;           // Page register action per row
    localparam int          P_SET       = 1;
    localparam int          P_OTHER_BAR = 2;
    localparam int          P_LEN2      = 3;
    localparam logic [63:0] PAGE_A      = 64'h0000_0002_4680_0000;

    // --------------------
    // Test table
    int row_qw   [NUM_ROWS] = '{5, 0, 37, 0, 5, 965, 37, 0, 5, 5};
    int row_bp   [NUM_ROWS] = '{0, 0, 0, 0, 50, 0, 50, 0, 0, 50};
    bit row_en   [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 0};
    bit row_sw   [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 1, 0, 1};
    int row_page [NUM_ROWS] = '{P_NONE, P_SET, P_NONE, P_OTHER_BAR, P_LEN2,
                                P_NONE, P_NONE, P_NONE, P_NONE, P_NONE};

    logic        trn_clk;
    logic        rst_n;
    logic [63:0] trn_rd;
    logic [7:0]  trn_rrem;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy_n;
    logic [6:0]  trn_rbar_hit_n;
    logic        trn_rdst_rdy_n;
    logic [63:0] trn_td;
    logic [7:0]  trn_trem_n;
    logic        trn_tsof_n;
    logic        trn_teof_n;
    logic        trn_tsrc_rdy_n;
    logic        trn_tdst_rdy_n;
    logic [9:0]  rx_commited_wr_addr;
    logic [9:0]  rx_commited_rd_addr;
    logic [9:0]  rx_rd_addr;
    logic [63:0] rx_rd_data;
    logic        cfg_interrupt_n;
    logic        cfg_interrupt_rdy_n;
    logic [7:0]  cfg_bus_number;
    logic [4:0]  cfg_device_number;
    logic [2:0]  cfg_function_number;

    // Reference state
    logic [63:0] mem [1024];                           // Receive buffer contents
    logic [9:0]  rd_addr_q;
    logic [9:0]  exp_rd;                               // Next qword the host should get
    logic [31:0] exp_hw;
    logic [63:0] page_model;
    logic        page_set;
    logic [31:0] sw_model;
    logic        armed_model;
    logic        tlp_open;
    int          beat_idx;
    int          cur_n;                                // Qwords in the open TLP
    int          tlp_cnt;
    int          irq_cnt;
    int          errors;
    int          failed_tests;
    int          bp_pct;
    int          cycle_cnt;
    int          cycle_limit;

    pcie_endpoint_driver #(
        .BUF_AW    (10),
        .BAR_INDEX (0)
    ) dut0 (
        .trn_clk             (trn_clk),
        .rst_n               (rst_n),
        .trn_rd              (trn_rd),
        .trn_rrem            (trn_rrem),
        .trn_rsof_n          (trn_rsof_n),
        .trn_reof_n          (trn_reof_n),
        .trn_rsrc_rdy_n      (trn_rsrc_rdy_n),
        .trn_rbar_hit_n      (trn_rbar_hit_n),
        .trn_rdst_rdy_n      (trn_rdst_rdy_n),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .rx_commited_wr_addr (rx_commited_wr_addr),
        .rx_commited_rd_addr (rx_commited_rd_addr),
        .rx_rd_addr          (rx_rd_addr),
        .rx_rd_data          (rx_rd_data),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .cfg_bus_number      (cfg_bus_number),
        .cfg_device_number   (cfg_device_number),
        .cfg_function_number (cfg_function_number)
    );

    always #10 trn_clk = ~trn_clk;                     // 20 ns period

    // --------------------
    // Buffer, back-pressure and interrupt core models
    always @(posedge trn_clk) rd_addr_q <= rx_rd_addr;

    always @(posedge trn_clk) begin
        #2;
        rx_rd_data     = mem[rd_addr_q];               // One cycle read latency
        trn_tdst_rdy_n = (int'($urandom % 100) < bp_pct);
        cfg_interrupt_rdy_n = !(rst_n && !cfg_interrupt_n && cfg_interrupt_rdy_n);
    end

    always @(posedge trn_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic require(input bit cond, input string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // Checks one accepted transmit beat against the TLP rule
    task automatic track_tx_beat();
        logic [63:0] exp_data;
        logic [9:0]  pending;
        logic        last;
        if (beat_idx == 0) begin
            pending = rx_commited_wr_addr - exp_rd;
            cur_n   = (pending > 10'd16) ? 16 : int'(pending);
            require(page_set, "TLP sent before the page address was written");
            require(cur_n != 0, "TLP sent with nothing committed");
            compare_value("rx_commited_rd_addr", 64'(rx_commited_rd_addr), 64'(exp_rd));
            exp_data = {1'b0, 2'b11, 5'h00, 14'h0, 10'(2 * cur_n),
                        cfg_bus_number, cfg_device_number, cfg_function_number,
                        8'h00, 8'hFF};                 // Tag 0, all bytes
            tlp_open = 1'b1;
        end else if (beat_idx == 1) begin
            exp_data = page_model + 64'(exp_hw) * 64'd8;   // Eight bytes per qword
        end else begin
            exp_data = mem[exp_rd + 10'(beat_idx - 2)];
        end
        last = (beat_idx == cur_n + 1);
        compare_value("trn_td", trn_td, exp_data);
        compare_value("trn_trem_n", 64'(trn_trem_n), 64'h0);
        compare_value("trn_tsof_n", 64'(trn_tsof_n), 64'(beat_idx != 0));
        compare_value("trn_teof_n", 64'(trn_teof_n), 64'(!last));
        if (last) begin
            exp_rd   = exp_rd + 10'(cur_n);
            exp_hw   = exp_hw + 32'(cur_n);
            tlp_cnt++;
            tlp_open = 1'b0;
            beat_idx = 0;
        end else begin
            beat_idx++;
        end
    endtask

    // Monitor at the falling edge, where the link is settled
    always @(negedge trn_clk) begin
        if (rst_n && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) track_tx_beat();
        if (rst_n && !cfg_interrupt_n) begin
            require(!tlp_open && trn_tsrc_rdy_n, "interrupt raised while a TLP is open");
            if (!cfg_interrupt_rdy_n) irq_cnt++;       // Core takes it next edge
        end
    end

    // 3DW memory write to the register BAR, len 2 adds a second data beat
    task automatic host_write(input logic [1:0] reg_idx, input logic [31:0] data,
                              input logic bar_ok, input int len);
        @(posedge trn_clk);
        #2;
        trn_rsrc_rdy_n = 1'b0;
        trn_rsof_n     = 1'b0;
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = bar_ok ? 7'h7E : 7'h7D;       // BAR0 or BAR1
        trn_rd = {1'b0, 2'b10, 5'h00, 14'h0, 10'(len), 16'h0100, 8'h00, 8'h0F};
        compare_value("trn_rdst_rdy_n", 64'(trn_rdst_rdy_n), 64'h0);
        @(posedge trn_clk);
        #2;
        trn_rsof_n = 1'b1;
        trn_reof_n = (len == 1) ? 1'b0 : 1'b1;
        trn_rd     = {28'hF000_000, reg_idx, 2'b00, data};
        if (len > 1) begin
            @(posedge trn_clk);
            #2;
            trn_reof_n = 1'b0;
            trn_rd     = {32'h0, ~data};
        end
        @(posedge trn_clk);
        #2;
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = 7'h7F;
    endtask

    // --------------------
    // One table row
    task automatic run_row(input int r);
        int         err_start;
        int         tlp_start;
        int         irq_start;
        int         exp_tlps;
        int         exp_irqs;
        logic [9:0] rd_start;
        logic [9:0] pending;
        err_start = errors;
        tlp_start = tlp_cnt;
        irq_start = irq_cnt;
        rd_start  = exp_rd;
        bp_pct    = row_bp[r];
        case (row_page[r])
            P_SET: begin
                page_model = PAGE_A;
                page_set   = 1'b1;
                host_write(2'd0, PAGE_A[31:0], 1'b1, 1);
                host_write(2'd1, PAGE_A[63:32], 1'b1, 1);
            end
            P_OTHER_BAR: host_write(2'd0, 32'hDEAD_0000, 1'b0, 1);
            P_LEN2:      host_write(2'd0, 32'hBEEF_0000, 1'b1, 2);
            default: ;
        endcase
        if (row_sw[r]) begin
            sw_model    = exp_hw;                      // Host caught up
            armed_model = 1'b1;
            host_write(2'd2, exp_hw, 1'b1, 1);
        end
        host_write(2'd3, {31'h0, row_en[r]}, 1'b1, 1);
        @(posedge trn_clk);
        #2;
        rx_commited_wr_addr = rx_commited_wr_addr + 10'(row_qw[r]);
        pending  = rx_commited_wr_addr - rd_start;
        exp_tlps = page_set ? (int'(pending) + 15) / 16 : 0;
        if (page_set) begin
            while (exp_rd != rx_commited_wr_addr) @(negedge trn_clk);
        end else begin
            repeat (40) @(negedge trn_clk);            // Nothing may move
        end
        exp_irqs = (armed_model && row_en[r] && exp_hw != sw_model) ? 1 : 0;
        if (exp_irqs > 0) begin
            armed_model = 1'b0;
            while (irq_cnt == irq_start) @(negedge trn_clk);
        end
        repeat (IRQ_WINDOW) @(negedge trn_clk);
        compare_value("rx_commited_rd_addr", 64'(rx_commited_rd_addr),
                      64'(page_set ? rx_commited_wr_addr : rd_start));
        require(tlp_cnt - tlp_start == exp_tlps,
                $sformatf("%0d TLPs sent, %0d expected", tlp_cnt - tlp_start, exp_tlps));
        require(irq_cnt - irq_start == exp_irqs,
                $sformatf("%0d interrupts, %0d expected", irq_cnt - irq_start, exp_irqs));
        if (errors != err_start) failed_tests++;
        $display("test %0d: %0d qwords, bp %0d, %0d TLPs, %0d irq, %s", r, row_qw[r],
                 row_bp[r], tlp_cnt - tlp_start, irq_cnt - irq_start,
                 (errors == err_start) ? "ok" : "FAILED");
    endtask

    initial begin
        trn_clk             = 1'b0;
        rst_n               = 1'b0;
        trn_rd              = '0;
        trn_rrem            = 8'h00;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7F;
        trn_tdst_rdy_n      = 1'b0;
        rx_commited_wr_addr = '0;
        rx_rd_data          = '0;
        cfg_interrupt_rdy_n = 1'b1;
        cfg_bus_number      = 8'h3A;
        cfg_device_number   = 5'h05;
        cfg_function_number = 3'h1;
        exp_rd       = '0;
        exp_hw       = '0;
        page_model   = '0;
        page_set     = 1'b0;
        sw_model     = '0;
        armed_model  = 1'b1;                           // Armed out of reset
        tlp_open     = 1'b0;
        beat_idx     = 0;
        cur_n        = 0;
        tlp_cnt      = 0;
        irq_cnt      = 0;
        errors       = 0;
        failed_tests = 0;
        bp_pct       = 0;
        cycle_cnt    = 0;
        void'($urandom(32'h595e_f8f2));
        for (int a = 0; a < 1024; a++) mem[a] = {$urandom, $urandom};
        cycle_limit = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += (row_qw[i] + 2 * ((row_qw[i] + 15) / 16) + 20) * 4;
        end
        repeat (16) @(posedge trn_clk);
        #2;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) run_row(r);
        $display("tests %0d, failed %0d, check errors %0d", NUM_ROWS, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/pcie_endpoint_driver.sv ====
// PCIe endpoint driver, receive path
// Connects the host register decoder, the receive DMA writer, the interrupt
// controller and the transmit link arbiter around the TRN and CFG ports
`timescale 1ns/1ps
`default_nettype none

module pcie_endpoint_driver import nic_rx_pkg::*; #(
    parameter int BUF_AW    = $bits(buf_addr_t),       // Receive buffer address width
    parameter int BAR_INDEX = 0                        // Register BAR
) (
    input  logic              trn_clk,
    input  logic              rst_n,
    // Rx link
    input  trn_data_t         trn_rd,
    input  logic [7:0]        trn_rrem,                // Full beats on register writes
    input  logic              trn_rsof_n,
    input  logic              trn_reof_n,
    input  logic              trn_rsrc_rdy_n,
    input  logic [6:0]        trn_rbar_hit_n,
    output logic              trn_rdst_rdy_n,
    // Tx link
    output trn_data_t         trn_td,
    output logic [7:0]        trn_trem_n,
    output logic              trn_tsof_n,
    output logic              trn_teof_n,
    output logic              trn_tsrc_rdy_n,
    input  logic              trn_tdst_rdy_n,
    // Receive buffer
    input  logic [BUF_AW-1:0] rx_commited_wr_addr,
    output logic [BUF_AW-1:0] rx_commited_rd_addr,
    output logic [BUF_AW-1:0] rx_rd_addr,
    input  trn_data_t         rx_rd_data,
    // Cfg
    output logic              cfg_interrupt_n,
    input  logic              cfg_interrupt_rdy_n,
    input  logic [7:0]        cfg_bus_number,
    input  logic [4:0]        cfg_device_number,
    input  logic [2:0]        cfg_function_number
);

    host_addr_t  huge_page_addr;
    logic        page_valid;
    qw_ptr_t     sw_ptr;
    logic        sw_ptr_wr;
    logic        irq_en;
    qw_ptr_t     hw_ptr;
    logic        req_dma;
    logic        gnt_dma;
    logic        req_irq;
    logic        gnt_irq;
    logic [15:0] requester_id;

    assign trn_rdst_rdy_n = 1'b0;                      // Always listen
    assign requester_id   = {cfg_bus_number, cfg_device_number, cfg_function_number};

    // --------------------
    // Host registers
    host_reg_decoder #(
        .BAR_INDEX (BAR_INDEX)
    ) host_reg_decoder0 (
        .trn_clk        (trn_clk),
        .rst_n          (rst_n),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .huge_page_addr (huge_page_addr),
        .page_valid     (page_valid),
        .sw_ptr         (sw_ptr),
        .sw_ptr_wr      (sw_ptr_wr),
        .irq_en         (irq_en)
    );

    // --------------------
    // Buffer to host DMA
    rx_dma_writer #(
        .BUF_AW (BUF_AW)
    ) rx_dma_writer0 (
        .trn_clk             (trn_clk),
        .rst_n               (rst_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .rx_commited_wr_addr (rx_commited_wr_addr),
        .rx_rd_data          (rx_rd_data),
        .requester_id        (requester_id),
        .huge_page_addr      (huge_page_addr),
        .page_valid          (page_valid),
        .gnt                 (gnt_dma),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .rx_rd_addr          (rx_rd_addr),
        .rx_commited_rd_addr (rx_commited_rd_addr),
        .hw_ptr              (hw_ptr),
        .req                 (req_dma)
    );

    // --------------------
    // Interrupt and token
    irq_ctrl irq_ctrl0 (
        .trn_clk             (trn_clk),
        .rst_n               (rst_n),
        .hw_ptr              (hw_ptr),
        .sw_ptr              (sw_ptr),
        .sw_ptr_wr           (sw_ptr_wr),
        .irq_en              (irq_en),
        .gnt                 (gnt_irq),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .req                 (req_irq),
        .cfg_interrupt_n     (cfg_interrupt_n)
    );

    link_arbiter link_arbiter0 (
        .trn_clk (trn_clk),
        .rst_n   (rst_n),
        .req_dma (req_dma),
        .req_irq (req_irq),
        .gnt_dma (gnt_dma),
        .gnt_irq (gnt_irq)
    );

endmodule

`default_nettype wire

// ==== hw/link_arbiter.sv ====
// Transmit link arbiter
// Hands one token between the DMA writer and the interrupt controller,
// round robin when both wait, held until the owner drops its request
`timescale 1ns/1ps
`default_nettype none

module link_arbiter (
    input  logic trn_clk,
    input  logic rst_n,
    input  logic req_dma,
    input  logic req_irq,
    output logic gnt_dma,
    output logic gnt_irq
);

    logic last_irq;                                    // Irq side served last

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            gnt_dma  <= 1'b0;
            gnt_irq  <= 1'b0;
            last_irq <= 1'b0;
        end else if (gnt_dma) begin
            if (!req_dma) gnt_dma <= 1'b0;             // Released
        end else if (gnt_irq) begin
            if (!req_irq) gnt_irq <= 1'b0;
        end else if (req_dma && (!req_irq || last_irq)) begin
            gnt_dma  <= 1'b1;
            last_irq <= 1'b0;
        end else if (req_irq) begin
            gnt_irq  <= 1'b1;
            last_irq <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/irq_ctrl.sv ====
// Interrupt controller
// Raises one legacy interrupt per software pointer write once the hardware
// pointer has moved, holding the link token so no TLP is open meanwhile
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import nic_rx_pkg::*; (
    input  logic    trn_clk,
    input  logic    rst_n,
    input  qw_ptr_t hw_ptr,
    input  qw_ptr_t sw_ptr,
    input  logic    sw_ptr_wr,
    input  logic    irq_en,
    input  logic    gnt,
    input  logic    cfg_interrupt_rdy_n,
    output logic    req,
    output logic    cfg_interrupt_n
);

    typedef enum logic [1:0] {
        S_IDLE, S_REQUEST, S_ASSERT, S_RELEASE
    } state_t;

    state_t state;
    logic   armed;                                     // One interrupt allowed

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            state           <= S_IDLE;
            armed           <= 1'b1;
            req             <= 1'b0;
            cfg_interrupt_n <= 1'b1;
        end else begin
            case (state)
                S_IDLE: if (armed && irq_en && hw_ptr != sw_ptr) begin
                    req   <= 1'b1;                     // Ask for the link
                    state <= S_REQUEST;
                end
                S_REQUEST: if (gnt) begin
                    cfg_interrupt_n <= 1'b0;
                    state           <= S_ASSERT;
                end
                S_ASSERT: if (!cfg_interrupt_rdy_n) begin
                    cfg_interrupt_n <= 1'b1;           // Core took it
                    req             <= 1'b0;
                    armed           <= 1'b0;
                    state           <= S_RELEASE;
                end
                S_RELEASE: if (!gnt) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (sw_ptr_wr) armed <= 1'b1;              // New pointer rearms
        end
    end

endmodule

`default_nettype wire

// ==== hw/rx_dma_writer.sv ====
// Receive DMA writer
// Moves committed receive-buffer qwords to the host huge page as 64-bit
// memory-write TLPs of up to MAX_BURST_QW qwords, and counts the hardware
// pointer. The buffer answers a read one cycle late, a one-entry holding
// register catches that data while the link back-pressures.
`timescale 1ns/1ps
`default_nettype none

module rx_dma_writer import nic_rx_pkg::*; #(
    parameter int BUF_AW = 10                          // Buffer address width
) (
    input  logic              trn_clk,
    input  logic              rst_n,
    input  logic              trn_tdst_rdy_n,
    input  logic [BUF_AW-1:0] rx_commited_wr_addr,
    input  trn_data_t         rx_rd_data,
    input  logic [15:0]       requester_id,
    input  host_addr_t        huge_page_addr,
    input  logic              page_valid,
    input  logic              gnt,
    output trn_data_t         trn_td,
    output logic [7:0]        trn_trem_n,
    output logic              trn_tsof_n,
    output logic              trn_teof_n,
    output logic              trn_tsrc_rdy_n,
    output logic [BUF_AW-1:0] rx_rd_addr,
    output logic [BUF_AW-1:0] rx_commited_rd_addr,
    output qw_ptr_t           hw_ptr,
    output logic              req
);

    typedef enum logic [2:0] {
        S_IDLE, S_REQUEST, S_HEADER, S_ADDRESS, S_DATA, S_COMMIT
    } state_t;

    state_t            state;
    logic [BUF_AW-1:0] avail;                          // Committed, not yet sent
    burst_len_t        burst;                          // Qwords in this TLP
    burst_len_t        fetch_cnt;                      // Buffer reads issued
    burst_len_t        load_cnt;                       // Data beats loaded
    logic              beat_ok;                        // Beat accepted this edge
    logic              out_free;                       // Output register can load
    logic              slot_free;
    logic              load_data;
    logic              rd_vld;                         // rx_rd_data is ours
    logic              hold_vld;
    logic              hold_nxt;
    trn_data_t         hold_q;                         // Skid entry
    logic              issue;                          // Take current read address
    logic [31:0]       tlp_dw0;
    logic [31:0]       tlp_dw1;
    host_addr_t        tlp_addr;

    // --------------------
    // Header fields
    assign avail    = rx_commited_wr_addr - rx_commited_rd_addr;
    assign tlp_dw0  = {1'b0, TLP_FMT_MWR64, TLP_TYPE_MEM, 14'h0, 4'h0, burst, 1'b0}; // 2n DW
    assign tlp_dw1  = {requester_id, 8'h00, 8'hFF};    // Tag 0, all bytes on
    assign tlp_addr = huge_page_addr + {29'h0, hw_ptr, 3'b000};
    assign trn_trem_n = 8'h00;                         // Always a full beat

    // --------------------
    // Data pipe
    assign beat_ok   = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign out_free  = trn_tsrc_rdy_n || !trn_tdst_rdy_n;
    assign slot_free = out_free && (state == S_ADDRESS || state == S_DATA);
    assign load_data = slot_free && (hold_vld || rd_vld) && (load_cnt != burst);
    assign hold_nxt  = (hold_vld || rd_vld) && !load_data;
    assign issue     = gnt && !hold_nxt && (fetch_cnt != burst)
                    && (state inside {S_REQUEST, S_HEADER, S_ADDRESS, S_DATA});

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            state               <= S_IDLE;
            req                 <= 1'b0;
            trn_tsof_n          <= 1'b1;
            trn_teof_n          <= 1'b1;
            trn_tsrc_rdy_n      <= 1'b1;
            rx_rd_addr          <= '0;
            rx_commited_rd_addr <= '0;
            hw_ptr              <= '0;
            burst               <= '0;
            fetch_cnt           <= '0;
            load_cnt            <= '0;
            rd_vld              <= 1'b0;
            hold_vld            <= 1'b0;
        end else begin
            rd_vld   <= issue;
            hold_vld <= hold_nxt;
            if (issue) begin
                rx_rd_addr <= rx_rd_addr + 1'b1;
                fetch_cnt  <= fetch_cnt + 1'b1;
            end
            if (load_data) begin
                trn_tsrc_rdy_n <= 1'b0;
                trn_teof_n     <= (load_cnt != burst - 1'b1); // Last qword
                load_cnt       <= load_cnt + 1'b1;
            end else if (slot_free) begin
                trn_tsrc_rdy_n <= 1'b1;                // Bubble, data not back yet
            end
            case (state)
                S_IDLE: if (page_valid && avail != '0) begin
                    burst     <= (avail > BUF_AW'(MAX_BURST_QW)) ? MAX_BURST_QW
                                                              : burst_len_t'(avail);
                    fetch_cnt <= '0;
                    load_cnt  <= '0;
                    req       <= 1'b1;
                    state     <= S_REQUEST;
                end
                S_REQUEST: if (gnt) begin
                    trn_tsrc_rdy_n <= 1'b0;            // Header beat out
                    trn_tsof_n     <= 1'b0;
                    state          <= S_HEADER;
                end
                S_HEADER: if (beat_ok) begin
                    trn_tsof_n <= 1'b1;
                    state      <= S_ADDRESS;
                end
                S_ADDRESS: if (beat_ok) state <= S_DATA;
                S_DATA: if (beat_ok && !trn_teof_n) begin
                    trn_tsrc_rdy_n      <= 1'b1;
                    trn_teof_n          <= 1'b1;
                    req                 <= 1'b0;
                    rx_commited_rd_addr <= rx_commited_rd_addr + BUF_AW'(burst);
                    hw_ptr              <= hw_ptr + qw_ptr_t'(burst);
                    state               <= S_COMMIT;
                end
                S_COMMIT: if (!gnt) state <= S_IDLE;   // Wait for token release
                default: state <= S_IDLE;
            endcase
        end
    end

    // Beat payload and skid entry
    always_ff @(posedge trn_clk) begin
        if (state == S_REQUEST) trn_td <= {tlp_dw0, tlp_dw1};
        else if (state == S_HEADER && beat_ok) trn_td <= tlp_addr;
        else if (load_data) trn_td <= hold_vld ? hold_q : rx_rd_data;
        if (rd_vld && !load_data) hold_q <= rx_rd_data;
    end

endmodule

`default_nettype wire

// ==== hw/host_reg_decoder.sv ====
// Host register decoder
// Picks single-DW 3DW memory writes to one BAR out of the TRN receive link
// and updates the huge page, software pointer and interrupt enable registers
`timescale 1ns/1ps
`default_nettype none

module host_reg_decoder import nic_rx_pkg::*; #(
    parameter int BAR_INDEX = 0                        // BAR that maps the registers
) (
    input  logic       trn_clk,
    input  logic       rst_n,
    input  trn_data_t  trn_rd,
    input  logic       trn_rsof_n,
    input  logic       trn_reof_n,
    input  logic       trn_rsrc_rdy_n,
    input  logic [6:0] trn_rbar_hit_n,
    output host_addr_t huge_page_addr,
    output logic       page_valid,
    output qw_ptr_t    sw_ptr,
    output logic       sw_ptr_wr,
    output logic       irq_en
);

    logic       beat;                                  // Beat on the link
    logic       in_tlp;                                // Past sof, waiting for eof
    logic       hdr_ok;                                // Beat 0 qualified
    logic       hdr_match;
    logic       wr_en;                                 // Register write this edge
    logic [1:0] reg_sel;

    assign beat    = !trn_rsrc_rdy_n;
    assign reg_sel = trn_rd[35:34];                    // Address bits 3:2

    // DW0 in the upper half of beat 0
    assign hdr_match = (trn_rd[62:61] == TLP_FMT_MWR32)
                    && (trn_rd[60:56] == TLP_TYPE_MEM)
                    && (trn_rd[41:32] == 10'd1)        // Single DW only
                    && !trn_rbar_hit_n[BAR_INDEX];

    assign wr_en = beat && trn_rsof_n && !trn_reof_n && in_tlp && hdr_ok;

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            in_tlp     <= 1'b0;
            hdr_ok     <= 1'b0;
            page_valid <= 1'b0;
            sw_ptr     <= '0;
            sw_ptr_wr  <= 1'b0;
            irq_en     <= 1'b0;
        end else begin
            sw_ptr_wr <= 1'b0;                         // One-cycle strobe
            if (beat && !trn_rsof_n) begin
                in_tlp <= trn_reof_n;                  // One-beat TLP never writes
                hdr_ok <= hdr_match;
            end else if (beat && !trn_reof_n) begin
                in_tlp <= 1'b0;
            end
            if (wr_en) begin
                case (reg_sel)
                    REG_PAGE_HI: page_valid <= 1'b1;
                    REG_SW_PTR: begin
                        sw_ptr    <= trn_rd[31:0];
                        sw_ptr_wr <= 1'b1;
                    end
                    REG_IRQ_EN:  irq_en <= trn_rd[0];
                    default: ;                         // Low page word below
                endcase
            end
        end
    end

    // Page address halves
    always_ff @(posedge trn_clk) begin
        if (wr_en && reg_sel == REG_PAGE_LO) huge_page_addr[31:0]  <= trn_rd[31:0];
        if (wr_en && reg_sel == REG_PAGE_HI) huge_page_addr[63:32] <= trn_rd[31:0];
    end

endmodule

`default_nettype wire

// ==== hw/nic_rx_pkg.sv ====
// NIC receive path shared definitions
// TRN beat and pointer types, TLP header codes and the BAR0 register map
`default_nettype none

package nic_rx_pkg;

    // --------------------
    // Types
    typedef logic [63:0] trn_data_t;                   // One TRN beat
    typedef logic [63:0] host_addr_t;                  // Host byte address
    typedef logic [31:0] qw_ptr_t;                     // Running qword count
    typedef logic [9:0]  buf_addr_t;                   // Receive buffer qword address
    typedef logic [4:0]  burst_len_t;                  // Qwords in one TLP, 0 to 16

    // --------------------
    // TLP codes
    localparam burst_len_t MAX_BURST_QW  = 5'd16;      // Largest write payload in qwords
    localparam logic [1:0] TLP_FMT_MWR64 = 2'h3;       // 4DW header with data
    localparam logic [1:0] TLP_FMT_MWR32 = 2'h2;       // 3DW header with data
    localparam logic [4:0] TLP_TYPE_MEM  = 5'h00;      // Memory request

    // --------------------
    // BAR0 register map, DW offset
    localparam logic [1:0] REG_PAGE_LO   = 2'd0;       // Page address 31:0
    localparam logic [1:0] REG_PAGE_HI   = 2'd1;       // Page address 63:32, sets valid
    localparam logic [1:0] REG_SW_PTR    = 2'd2;       // Software read pointer
    localparam logic [1:0] REG_IRQ_EN    = 2'd3;       // Bit 0 enables the interrupt

endpackage

`default_nettype wire
